// ==== design/credit_fifo.sv ====
// circular buffer with first-word fall-through read and an occupancy count
// DEPTH must be at least 2; push when full and pop when empty are illegal
`timescale 1ns/1ps
`default_nettype none

module credit_fifo
#(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 4
)
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       push,
   input  payload_t                   push_data,
   input  logic                       pop,
   output payload_t                   pop_data,
   output logic                       empty,
   output logic [$clog2(DEPTH+1)-1:0] count
);

   localparam int AW = $clog2(DEPTH);
   localparam int CW = $clog2(DEPTH + 1);

   payload_t      mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;

   assign pop_data = mem[rd_ptr];
   assign empty    = (count == '0);

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      !(push && count == CW'(DEPTH)));

   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      !(pop && empty));

endmodule

`default_nettype wire

// ==== design/exec_alu.sv ====
// second pipeline stage, data result and condition codes
// byte forms keep the destination upper byte except movb, which sign-extends
// non-alu classes carry the issue cc through unchanged
`timescale 1ns/1ps
`default_nettype none

module exec_alu
   import pdp_exec_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    op_valid,
   input  exe_op_t op,
   output logic    alu_valid,
   output exe_op_t alu_op,
   output word_t   alu_result,
   output cc_t     alu_cc,
   output logic    result_we
);

   word_t a;
   word_t b;
   word_t one;
   word_t r;
   word_t result;
   byte_t res_hi;
   logic  lsb;
   logic  cin;
   logic  carry;
   logic  we;
   cc_t   cc;

   // byte operands sit in the upper byte so that bit 15 gives sign, carry and overflow
   assign a   = op.byte_op ? {op.req.src[7:0], 8'h00} : op.req.src;
   assign b   = op.byte_op ? {op.req.dst[7:0], 8'h00} : op.req.dst;
   assign one = op.byte_op ? 16'h0100 : 16'h0001;
   assign lsb = op.byte_op ? b[8] : b[0];
   assign cin = op.req.cc.c;

   always_comb
   begin
      r     = b;
      carry = cin;
      case (op.alu_fn)
         FN_MOV:  r = a;
         FN_CMP:  {carry, r} = {1'b0, a} - {1'b0, b};
         FN_BIT:  r = a & b;
         FN_BIC:  r = ~a & b;
         FN_BIS:  r = a | b;
         FN_ADD:  {carry, r} = {1'b0, a} + {1'b0, b};
         FN_SUB:  {carry, r} = {1'b0, b} - {1'b0, a};
         FN_XOR:  r = a ^ b;
         FN_CLR:  r = 16'h0000;
         FN_COM:  r = ~b;
         FN_INC:  r = b + one;
         FN_DEC:  r = b - one;
         FN_NEG:  r = 16'h0000 - b;
         FN_ADC:  {carry, r} = {1'b0, b} + {1'b0, (cin ? one : 16'h0000)};
         FN_SBC:  {carry, r} = {1'b0, b} - {1'b0, (cin ? one : 16'h0000)};
         FN_ROR:  {r, carry} = {cin, b[15:1], lsb};
         FN_ROL:  {carry, r} = {b, 1'b0} | {1'b0, (cin ? one : 16'h0000)};
         FN_ASR:  {r, carry} = {b[15], b[15:1], lsb};
         FN_ASL:  {carry, r} = {b, 1'b0};
         FN_SWAB: r = {op.req.dst[7:0], op.req.dst[15:8]};
         default: r = b;
      endcase

      // n and z from the upper byte in byte mode, low garbage ignored
      cc   = op.req.cc;
      cc.n = r[15];
      cc.z = op.byte_op ? (r[15:8] == 8'h00) : (r == 16'h0000);
      cc.v = 1'b0;
      case (op.alu_fn)
         FN_CMP:  {cc.v, cc.c} = {(a[15] ^ b[15]) & ~(b[15] ^ r[15]), carry};
         FN_ADD:  {cc.v, cc.c} = {~(a[15] ^ b[15]) & (a[15] ^ r[15]), carry};
         FN_SUB:  {cc.v, cc.c} = {(a[15] ^ b[15]) & ~(a[15] ^ r[15]), carry};
         FN_CLR:  cc.c = 1'b0;
         FN_COM:  cc.c = 1'b1;
         FN_INC:  cc.v = ~b[15] & r[15];
         FN_DEC:  cc.v = b[15] & ~r[15];
         FN_NEG:  {cc.v, cc.c} = {b[15] & r[15], ~cc.z};
         FN_ADC:  {cc.v, cc.c} = {~b[15] & r[15], carry};
         FN_SBC:  {cc.v, cc.c} = {b[15] & ~r[15], carry};
         FN_TST:  cc.c = 1'b0;
         FN_ROR, FN_ROL, FN_ASR, FN_ASL:
            {cc.v, cc.c} = {r[15] ^ carry, carry};
         FN_SWAB: {cc.n, cc.z, cc.c} = {r[7], (r[7:0] == 8'h00), 1'b0};
         FN_NOP:  cc = op.req.cc;
         default: cc.v = 1'b0;
      endcase

      res_hi = op.req.dst[15:8];
      if (op.alu_fn == FN_MOV && op.byte_op)
         res_hi = {8{r[15]}};
      result = op.byte_op ? {res_hi, r[15:8]} : r;

      // compare and test forms only update the flags
      we = !(op.alu_fn inside {FN_NOP, FN_CMP, FN_BIT, FN_TST});
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         alu_valid <= 1'b0;
      else
         alu_valid <= op_valid;
      alu_op     <= op;
      alu_result <= result;
      alu_cc     <= cc;
      result_we  <= we;
   end

   // decode gives a function only to the double and single classes
   a_fn_class: assert property (@(posedge clk) disable iff (rst)
      op_valid && op.cls != CLS_DOUBLE && op.cls != CLS_SINGLE |-> op.alu_fn == FN_NOP);

endmodule

`default_nettype wire

// ==== design/exec_decode.sv ====
// first pipeline stage, classifies the instruction word
// opcodes outside the kept set leave with class none and no function
`timescale 1ns/1ps
`default_nettype none

module exec_decode
   import pdp_exec_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   input  exe_req_t in_req,
   output logic     op_valid,
   output exe_op_t  op
);

   exe_op_t next_op;
   word_t   isn;

   assign isn = in_req.isn;

   always_comb
   begin
      next_op = '{req: in_req, cls: CLS_NONE, alu_fn: FN_NOP, byte_op: 1'b0,
                  br_cond: BR_NONE};
      if (isn[14:12] >= OP_MOV && isn[14:12] <= OP_BIS)
      begin
         // mov through bis, offset from mov in opcode order
         next_op.cls     = CLS_DOUBLE;
         next_op.byte_op = isn[15];
         next_op.alu_fn  = alu_fn_e'(FN_MOV + (isn[14:12] - OP_MOV));
      end
      else if (isn[15:12] == OP_ADD || isn[15:12] == OP_SUB)
      begin
         next_op.cls    = CLS_DOUBLE;
         next_op.alu_fn = isn[15] ? FN_SUB : FN_ADD;
      end
      else if (isn[15:9] == OP_XOR)
      begin
         next_op.cls    = CLS_DOUBLE;
         next_op.alu_fn = FN_XOR;
      end
      else if (isn[14:12] == 3'o0 && isn[11:6] >= OP_CLR && isn[11:6] <= OP_ASL)
      begin
         next_op.cls     = CLS_SINGLE;
         next_op.byte_op = isn[15];
         next_op.alu_fn  = alu_fn_e'(FN_CLR + (isn[11:6] - OP_CLR));
      end
      else if (isn[15:6] == OP_SWAB)
      begin
         next_op.cls    = CLS_SINGLE;
         next_op.alu_fn = FN_SWAB;
      end
      else if (isn[15:6] == OP_JMP)
         next_op.cls = CLS_JMP;
      else if (isn[15:5] == OP_CCOP)
         next_op.cls = CLS_CCOP;
      else if (isn[14:11] == OP_BR_BASE && (isn[15] || isn[10:8] != 3'o0))
      begin
         next_op.cls     = CLS_BRANCH;
         next_op.br_cond = br_cond_e'({isn[15], isn[10:8]});
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         op_valid <= 1'b0;
      else
         op_valid <= in_valid;
      op <= next_op;
   end

endmodule

`default_nettype wire

// ==== design/exec_flow.sv ====
// third pipeline stage, branch and jmp resolution, flag operations, response build
// branch conditions use the cc carried with the request
`timescale 1ns/1ps
`default_nettype none

module exec_flow
   import pdp_exec_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     alu_valid,
   input  exe_op_t  alu_op,
   input  word_t    alu_result,
   input  cc_t      alu_cc,
   input  logic     result_we,
   output logic     rsp_valid,
   output exe_rsp_t rsp
);

   exe_req_t req;
   exe_rsp_t next_rsp;
   word_t    offset;
   logic     taken;

   assign req    = alu_op.req;
   // word offset, sign-extended and doubled
   assign offset = {{7{req.isn[7]}}, req.isn[7:0], 1'b0};

   always_comb
   begin
      case (alu_op.br_cond)
         BR_ALWAYS: taken = 1'b1;
         BR_NE:     taken = ~req.cc.z;
         BR_EQ:     taken = req.cc.z;
         BR_GE:     taken = ~(req.cc.n ^ req.cc.v);
         BR_LT:     taken = req.cc.n ^ req.cc.v;
         BR_GT:     taken = ~(req.cc.z | (req.cc.n ^ req.cc.v));
         BR_LE:     taken = req.cc.z | (req.cc.n ^ req.cc.v);
         BR_PL:     taken = ~req.cc.n;
         BR_MI:     taken = req.cc.n;
         BR_HI:     taken = ~(req.cc.c | req.cc.z);
         BR_LOS:    taken = req.cc.c | req.cc.z;
         BR_VC:     taken = ~req.cc.v;
         BR_VS:     taken = req.cc.v;
         BR_CC:     taken = ~req.cc.c;
         BR_CS:     taken = req.cc.c;
         default:   taken = 1'b0;
      endcase
   end

   always_comb
   begin
      next_rsp.tag       = req.tag;
      next_rsp.result    = alu_result;
      next_rsp.result_we = result_we;
      next_rsp.cc        = alu_cc;
      next_rsp.cc_we     = (alu_op.cls == CLS_DOUBLE) || (alu_op.cls == CLS_SINGLE);
      next_rsp.new_pc    = req.pc;
      next_rsp.pc_we     = 1'b0;
      case (alu_op.cls)
         CLS_BRANCH:
         begin
            next_rsp.new_pc = req.pc + offset;
            next_rsp.pc_we  = taken;
         end
         CLS_JMP:
         begin
            next_rsp.new_pc = req.dst_ea;
            next_rsp.pc_we  = 1'b1;
         end
         CLS_CCOP:
         begin
            // isn[4] set or clear, isn[3:0] selects n z v c
            next_rsp.cc    = req.isn[4] ? (alu_cc | req.isn[3:0]) : (alu_cc & ~req.isn[3:0]);
            next_rsp.cc_we = 1'b1;
         end
         default:
            next_rsp.pc_we = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         rsp_valid <= 1'b0;
      else
         rsp_valid <= alu_valid;
      rsp <= next_rsp;
   end

endmodule

`default_nettype wire

// ==== design/exec_retire.sv ====
// output buffer with a credit counter toward the consumer
// issue_ok reserves a buffer slot for every packet still in the three stages
// out_valid and out_rsp are registered, one cycle after the credit is spent
`timescale 1ns/1ps
`default_nettype none

module exec_retire
   import pdp_exec_pkg::*;
#(
   parameter int OUT_DEPTH   = 4,
   parameter int OUT_CREDITS = 2
)
(
   input  logic     clk,
   input  logic     rst,
   input  logic     issue,
   input  logic     rsp_valid,
   input  exe_rsp_t rsp,
   input  logic     out_credit,
   output logic     issue_ok,
   output logic     out_valid,
   output exe_rsp_t out_rsp
);

   localparam int CW = $clog2(OUT_DEPTH + 1);
   localparam int KW = $clog2(OUT_CREDITS + 1);

   logic [CW-1:0] fifo_count;
   logic [CW-1:0] in_flight;
   logic [KW-1:0] credits;
   logic          fifo_empty;
   logic          send;
   exe_rsp_t      head;

   credit_fifo #(
      .payload_t(exe_rsp_t),
      .DEPTH    (OUT_DEPTH)
   ) u_rsp_fifo (
      .clk      (clk),
      .rst      (rst),
      .push     (rsp_valid),
      .push_data(rsp),
      .pop      (send),
      .pop_data (head),
      .empty    (fifo_empty),
      .count    (fifo_count)
   );

   assign issue_ok = ({1'b0, fifo_count} + {1'b0, in_flight}) < (CW + 1)'(OUT_DEPTH);
   assign send     = !fifo_empty && (credits != '0);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         in_flight <= '0;
         credits   <= KW'(OUT_CREDITS);
         out_valid <= 1'b0;
      end
      else
      begin
         case ({issue, rsp_valid})
            2'b10:   in_flight <= in_flight + 1'b1;
            2'b01:   in_flight <= in_flight - 1'b1;
            default: in_flight <= in_flight;
         endcase
         case ({out_credit, send})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
         out_valid <= send;
      end
      out_rsp <= head;
   end

   // the consumer never returns more credits than it was given
   a_credit_bound: assert property (@(posedge clk) disable iff (rst)
      credits <= KW'(OUT_CREDITS));

endmodule

`default_nettype wire

// ==== design/pdp_exec_pkg.sv ====
// widths, opcode fields, enums and packet structs for the pdp-11 execute pipeline
// opcode constants cover only the instructions this stage executes
`default_nettype none

package pdp_exec_pkg;

   typedef logic [15:0] word_t;
   typedef logic [7:0]  byte_t;
   typedef logic [7:0]  tag_t;

   typedef struct packed {
      logic n;
      logic z;
      logic v;
      logic c;
   } cc_t;

   typedef struct packed {
      word_t isn;
      word_t pc;
      word_t src;
      word_t dst;
      word_t dst_ea;
      cc_t   cc;
      tag_t  tag;
   } exe_req_t;

   typedef enum logic [2:0] {
      CLS_NONE, CLS_DOUBLE, CLS_SINGLE, CLS_BRANCH, CLS_JMP, CLS_CCOP
   } exe_class_e;

   // double and single groups are listed in opcode order
   typedef enum logic [4:0] {
      FN_NOP, FN_MOV, FN_CMP, FN_BIT, FN_BIC, FN_BIS, FN_ADD, FN_SUB, FN_XOR,
      FN_CLR, FN_COM, FN_INC, FN_DEC, FN_NEG, FN_ADC, FN_SBC, FN_TST,
      FN_ROR, FN_ROL, FN_ASR, FN_ASL, FN_SWAB
   } alu_fn_e;

   // encoding is {isn[15], isn[10:8]} of the branch word
   typedef enum logic [3:0] {
      BR_NONE = 4'd0,  BR_ALWAYS = 4'd1, BR_NE = 4'd2,  BR_EQ = 4'd3,
      BR_GE   = 4'd4,  BR_LT     = 4'd5, BR_GT = 4'd6,  BR_LE = 4'd7,
      BR_PL   = 4'd8,  BR_MI     = 4'd9, BR_HI = 4'd10, BR_LOS = 4'd11,
      BR_VC   = 4'd12, BR_VS     = 4'd13, BR_CC = 4'd14, BR_CS = 4'd15
   } br_cond_e;

   typedef struct packed {
      exe_req_t   req;
      exe_class_e cls;
      alu_fn_e    alu_fn;
      logic       byte_op;
      br_cond_e   br_cond;
   } exe_op_t;

   typedef struct packed {
      tag_t  tag;
      word_t result;
      logic  result_we;
      cc_t   cc;
      logic  cc_we;
      word_t new_pc;
      logic  pc_we;
   } exe_rsp_t;

   // isn[14:12] of the double-operand group, isn[15] marks the byte form
   localparam logic [2:0]  OP_MOV     = 3'o1;
   localparam logic [2:0]  OP_BIS     = 3'o5;
   // isn[15:12], word only
   localparam logic [3:0]  OP_ADD     = 4'o06;
   localparam logic [3:0]  OP_SUB     = 4'o16;
   // isn[15:9]
   localparam logic [6:0]  OP_XOR     = 7'o074;
   // isn[11:6] of the single-operand group, with isn[14:12] zero
   localparam logic [5:0]  OP_CLR     = 6'o50;
   localparam logic [5:0]  OP_ASL     = 6'o63;
   // isn[15:6]
   localparam logic [9:0]  OP_JMP     = 10'o0001;
   localparam logic [9:0]  OP_SWAB    = 10'o0003;
   // isn[15:5], clear and set flag group 000240-000277
   localparam logic [10:0] OP_CCOP    = 11'o0005;
   // isn[14:11] shared by both branch groups
   localparam logic [3:0]  OP_BR_BASE = 4'b0000;

endpackage

`default_nettype wire

// ==== design/pdp_exec_top.sv ====
// pdp-11 execute pipeline with credit flow control on both sides
// the producer starts with IN_DEPTH credits, the consumer grants OUT_CREDITS
// pop to result write is 3 cycles, packets leave in arrival order
`timescale 1ns/1ps
`default_nettype none

module pdp_exec_top
   import pdp_exec_pkg::*;
#(
   parameter int IN_DEPTH    = 4,
   parameter int OUT_DEPTH   = 4,
   parameter int OUT_CREDITS = 2
)
(
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   input  exe_req_t in_req,
   output logic     in_credit,
   output logic     out_valid,
   output exe_rsp_t out_rsp,
   input  logic     out_credit
);

   exe_req_t in_head;
   logic     in_empty;
   logic     pop;
   logic     issue_ok;
   logic     op_valid;
   exe_op_t  op;
   logic     alu_valid;
   exe_op_t  alu_op;
   word_t    alu_result;
   cc_t      alu_cc;
   logic     result_we;
   logic     rsp_valid;
   exe_rsp_t rsp;

   // every pop frees an input slot and returns a credit to the producer
   assign pop       = !in_empty && issue_ok;
   assign in_credit = pop;

   credit_fifo #(
      .payload_t(exe_req_t),
      .DEPTH    (IN_DEPTH)
   ) u_in_fifo (
      .clk      (clk),
      .rst      (rst),
      .push     (in_valid),
      .push_data(in_req),
      .pop      (pop),
      .pop_data (in_head),
      .empty    (in_empty),
      .count    ()
   );

   exec_decode u_decode (
      .clk     (clk),
      .rst     (rst),
      .in_valid(pop),
      .in_req  (in_head),
      .op_valid(op_valid),
      .op      (op)
   );

   exec_alu u_alu (
      .clk       (clk),
      .rst       (rst),
      .op_valid  (op_valid),
      .op        (op),
      .alu_valid (alu_valid),
      .alu_op    (alu_op),
      .alu_result(alu_result),
      .alu_cc    (alu_cc),
      .result_we (result_we)
   );

   exec_flow u_flow (
      .clk       (clk),
      .rst       (rst),
      .alu_valid (alu_valid),
      .alu_op    (alu_op),
      .alu_result(alu_result),
      .alu_cc    (alu_cc),
      .result_we (result_we),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

   exec_retire #(
      .OUT_DEPTH  (OUT_DEPTH),
      .OUT_CREDITS(OUT_CREDITS)
   ) u_retire (
      .clk       (clk),
      .rst       (rst),
      .issue     (pop),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .out_credit(out_credit),
      .issue_ok  (issue_ok),
      .out_valid (out_valid),
      .out_rsp   (out_rsp)
   );

endmodule

`default_nettype wire

// ==== pdp_exec.f ====
+incdir+verification
design/pdp_exec_pkg.sv
design/credit_fifo.sv
design/exec_decode.sv
design/exec_alu.sv
design/exec_flow.sv
design/exec_retire.sv
design/pdp_exec_top.sv
verification/tb_pdp_exec.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the output

verilator --binary --timing --top-module tb_pdp_exec -f pdp_exec.f -o tb_sim \
   && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== verification/tb_vectors.svh ====
// request and expected response table, pc is 0x0200 and dst_ea 0x3000 for every row
// don't-care fields follow their write enables
// columns: isn, src, dst, cc in (nzvc), result, result_we, cc out, cc_we, new_pc, pc_we
task automatic load_vectors();
   add_vec(16'o010102, 16'h8000, 16'h1234, 4'b0001, 16'h8000, 1, 4'b1001, 1, 16'h0000, 0);
   add_vec(16'o020102, 16'h0001, 16'h0002, 4'b0000, 16'h0000, 0, 4'b1001, 1, 16'h0000, 0);
   add_vec(16'o020102, 16'h8000, 16'h0001, 4'b0000, 16'h0000, 0, 4'b0010, 1, 16'h0000, 0);
   add_vec(16'o030102, 16'h00f0, 16'h0f0f, 4'b0001, 16'h0000, 0, 4'b0101, 1, 16'h0000, 0);
   add_vec(16'o040102, 16'h00ff, 16'h1234, 4'b1111, 16'h1200, 1, 4'b0001, 1, 16'h0000, 0);
   add_vec(16'o050102, 16'h8001, 16'h0100, 4'b0000, 16'h8101, 1, 4'b1000, 1, 16'h0000, 0);
   add_vec(16'o060102, 16'h7fff, 16'h0001, 4'b0000, 16'h8000, 1, 4'b1010, 1, 16'h0000, 0);
   add_vec(16'o060102, 16'hffff, 16'h0001, 4'b0000, 16'h0000, 1, 4'b0101, 1, 16'h0000, 0);
   add_vec(16'o160102, 16'h0001, 16'h0003, 4'b0000, 16'h0002, 1, 4'b0000, 1, 16'h0000, 0);
   add_vec(16'o160102, 16'h0003, 16'h0001, 4'b0000, 16'hfffe, 1, 4'b1001, 1, 16'h0000, 0);
   add_vec(16'o074201, 16'hff00, 16'h0ff0, 4'b0001, 16'hf0f0, 1, 4'b1001, 1, 16'h0000, 0);
   add_vec(16'o110102, 16'h0080, 16'h1234, 4'b0000, 16'hff80, 1, 4'b1000, 1, 16'h0000, 0);
   add_vec(16'o120102, 16'h1201, 16'h3402, 4'b0000, 16'h0000, 0, 4'b1001, 1, 16'h0000, 0);
   add_vec(16'o130102, 16'hff0f, 16'h00f0, 4'b0000, 16'h0000, 0, 4'b0100, 1, 16'h0000, 0);
   add_vec(16'o140102, 16'h000f, 16'hab3c, 4'b0000, 16'hab30, 1, 4'b0000, 1, 16'h0000, 0);
   add_vec(16'o150102, 16'h0080, 16'h5501, 4'b0000, 16'h5581, 1, 4'b1000, 1, 16'h0000, 0);
   add_vec(16'o005001, 16'h0000, 16'h1234, 4'b1011, 16'h0000, 1, 4'b0100, 1, 16'h0000, 0);
   add_vec(16'o005101, 16'h0000, 16'h00ff, 4'b0000, 16'hff00, 1, 4'b1001, 1, 16'h0000, 0);
   add_vec(16'o005201, 16'h0000, 16'h7fff, 4'b0001, 16'h8000, 1, 4'b1011, 1, 16'h0000, 0);
   add_vec(16'o005301, 16'h0000, 16'h8000, 4'b0000, 16'h7fff, 1, 4'b0010, 1, 16'h0000, 0);
   add_vec(16'o005401, 16'h0000, 16'h0001, 4'b0000, 16'hffff, 1, 4'b1001, 1, 16'h0000, 0);
   add_vec(16'o005501, 16'h0000, 16'hffff, 4'b0001, 16'h0000, 1, 4'b0101, 1, 16'h0000, 0);
   add_vec(16'o005601, 16'h0000, 16'h0000, 4'b0001, 16'hffff, 1, 4'b1001, 1, 16'h0000, 0);
   add_vec(16'o005701, 16'h0000, 16'h8000, 4'b0011, 16'h0000, 0, 4'b1000, 1, 16'h0000, 0);
   add_vec(16'o006001, 16'h0000, 16'h0003, 4'b0001, 16'h8001, 1, 4'b1001, 1, 16'h0000, 0);
   add_vec(16'o006101, 16'h0000, 16'h8000, 4'b0000, 16'h0000, 1, 4'b0111, 1, 16'h0000, 0);
   add_vec(16'o006201, 16'h0000, 16'h8002, 4'b0000, 16'hc001, 1, 4'b1010, 1, 16'h0000, 0);
   add_vec(16'o006301, 16'h0000, 16'h4001, 4'b0000, 16'h8002, 1, 4'b1010, 1, 16'h0000, 0);
   add_vec(16'o106201, 16'h0000, 16'h1281, 4'b0000, 16'h12c0, 1, 4'b1001, 1, 16'h0000, 0);
   add_vec(16'o000301, 16'h0000, 16'h80ff, 4'b0001, 16'hff80, 1, 4'b1000, 1, 16'h0000, 0);
   add_vec(16'o000402, 16'h0000, 16'h0000, 4'b0000, 16'h0000, 0, 4'b0000, 0, 16'h0204, 1);
   add_vec(16'o001375, 16'h0000, 16'h0000, 4'b0100, 16'h0000, 0, 4'b0000, 0, 16'h0000, 0);
   add_vec(16'o001775, 16'h0000, 16'h0000, 4'b0100, 16'h0000, 0, 4'b0000, 0, 16'h01fa, 1);
   add_vec(16'o002410, 16'h0000, 16'h0000, 4'b1000, 16'h0000, 0, 4'b0000, 0, 16'h0210, 1);
   add_vec(16'o101010, 16'h0000, 16'h0000, 4'b0000, 16'h0000, 0, 4'b0000, 0, 16'h0210, 1);
   add_vec(16'o103410, 16'h0000, 16'h0000, 4'b0000, 16'h0000, 0, 4'b0000, 0, 16'h0000, 0);
   add_vec(16'o000137, 16'h0000, 16'h0000, 4'b0000, 16'h0000, 0, 4'b0000, 0, 16'h3000, 1);
   add_vec(16'o000261, 16'h0000, 16'h0000, 4'b0100, 16'h0000, 0, 4'b0101, 1, 16'h0000, 0);
   add_vec(16'o000254, 16'h0000, 16'h0000, 4'b1111, 16'h0000, 0, 4'b0011, 1, 16'h0000, 0);
   add_vec(16'o070102, 16'h0005, 16'h0006, 4'b0000, 16'h0000, 0, 4'b0000, 0, 16'h0000, 0);
   add_vec(16'o000000, 16'h0000, 16'h0000, 4'b0000, 16'h0000, 0, 4'b0000, 0, 16'h0000, 0);
endtask

// ==== verification/tb_pdp_exec.sv ====
// testbench for pdp_exec_top, table driven with credit models on both sides
// consumer credits come back with LFSR gaps and are withheld for a window
// fields guarded by a write enable are only compared when it is set
`timescale 1ns/1ps
`default_nettype none

module tb_pdp_exec
   import pdp_exec_pkg::*;
();

   localparam int IN_DEPTH    = 4;
   localparam int OUT_DEPTH   = 4;
   localparam int OUT_CREDITS = 2;
   localparam int NVEC        = 41;
   localparam int TIMEOUT     = NVEC * 20 + 100;

   logic     clk;
   logic     rst;
   logic     in_valid;
   exe_req_t in_req;
   logic     in_credit;
   logic     out_valid;
   exe_rsp_t out_rsp;
   logic     out_credit;

   exe_req_t vec_req [NVEC];
   exe_rsp_t vec_rsp [NVEC];
   exe_rsp_t exp_q [$];
   int       nloaded = 0;
   int       model_credits;
   int       prod_credits;

   pdp_exec_top #(
      .IN_DEPTH   (IN_DEPTH),
      .OUT_DEPTH  (OUT_DEPTH),
      .OUT_CREDITS(OUT_CREDITS)
   ) u_dut (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_req    (in_req),
      .in_credit (in_credit),
      .out_valid (out_valid),
      .out_rsp   (out_rsp),
      .out_credit(out_credit)
   );

   task automatic add_vec(input word_t isn, input word_t src, input word_t dst,
                          input cc_t cc_in, input word_t result, input logic rwe,
                          input cc_t cc_out, input logic cwe, input word_t new_pc,
                          input logic pwe);
      vec_req[nloaded] = '{isn: isn, pc: 16'h0200, src: src, dst: dst, dst_ea: 16'h3000,
                           cc: cc_in, tag: tag_t'(nloaded)};
      vec_rsp[nloaded] = '{tag: tag_t'(nloaded), result: result, result_we: rwe,
                           cc: cc_out, cc_we: cwe, new_pc: new_pc, pc_we: pwe};
      nloaded++;
   endtask

   `include "tb_vectors.svh"

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
         stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_cc(input string name, input cc_t got, input cc_t exp);
      if (got !== exp)
         stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_tag(input string name, input tag_t got, input tag_t exp);
      if (got !== exp)
         stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_rsp(input exe_rsp_t got, input exe_rsp_t exp);
      check_tag("out_rsp.tag", got.tag, exp.tag);
      check_bit("out_rsp.result_we", got.result_we, exp.result_we);
      check_bit("out_rsp.cc_we", got.cc_we, exp.cc_we);
      check_bit("out_rsp.pc_we", got.pc_we, exp.pc_we);
      if (exp.result_we)
         check_word("out_rsp.result", got.result, exp.result);
      if (exp.cc_we)
         check_cc("out_rsp.cc", got.cc, exp.cc);
      if (exp.pc_we)
         check_word("out_rsp.new_pc", got.new_pc, exp.new_pc);
   endtask

   task automatic check_credit();
      if (int'(u_dut.u_retire.credits) != model_credits)
         stop_run($sformatf("Fail credits got %h expected %h",
                            u_dut.u_retire.credits, model_credits));
      if (prod_credits > IN_DEPTH)
         stop_run("the DUT returned more input credits than the producer spent");
   endtask

   // galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      logic [31:0] lfsr;
      int          cycle;
      int          sent;
      int          got;
      int          owed;
      logic        ret_pending;
      lfsr          = 32'h736a;
      cycle         = 0;
      sent          = 0;
      got           = 0;
      owed          = 0;
      ret_pending   = 1'b0;
      model_credits = OUT_CREDITS;
      prod_credits  = IN_DEPTH;
      rst           = 1'b1;
      in_valid      = 1'b0;
      in_req        = '0;
      out_credit    = 1'b0;
      load_vectors();
      if (nloaded != NVEC)
         stop_run("the vector table does not hold the expected number of rows");

      repeat (2)
      begin
         @(posedge clk);
         #1;
         check_bit("out_valid", out_valid, 1'b0);
         check_bit("in_credit", in_credit, 1'b0);
      end
      rst = 1'b0;

      while (got < NVEC)
      begin
         @(posedge clk);
         #1;
         cycle++;
         if (cycle > TIMEOUT)
            stop_run("timeout while waiting for responses");
         if (cycle == 1)
         begin
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("in_credit", in_credit, 1'b0);
         end
         // a send needs a credit held before this edge
         if (out_valid)
         begin
            if (model_credits == 0)
               stop_run("out_valid rose while the consumer held no credit");
            if (exp_q.size() == 0)
               stop_run("a response arrived with no request outstanding");
            model_credits--;
            owed++;
            check_rsp(out_rsp, exp_q.pop_front());
            got++;
         end
         if (ret_pending)
            model_credits++;
         ret_pending = 1'b0;
         check_credit();

         in_valid   = 1'b0;
         out_credit = 1'b0;
         if (sent < NVEC && prod_credits > 0)
         begin
            in_valid = 1'b1;
            in_req   = vec_req[sent];
            exp_q.push_back(vec_rsp[sent]);
            sent++;
            prod_credits--;
         end
         // slot frees at the coming edge and is usable next cycle
         if (in_credit)
            prod_credits++;
         // credits withheld for a while so the output buffer fills
         if (owed > 0 && (cycle < 30 || cycle >= 70))
         begin
            if (lfsr[0])
            begin
               out_credit  = 1'b1;
               ret_pending = 1'b1;
               owed--;
            end
            lfsr = lfsr_step(lfsr);
         end
      end

      // nothing more may come out
      repeat (10)
      begin
         @(posedge clk);
         #1;
         check_bit("out_valid", out_valid, 1'b0);
         check_bit("in_credit", in_credit, 1'b0);
      end

      if (prod_credits == IN_DEPTH)
      begin
         $display("TEST PASS");
         $finish;
      end
      else
         stop_run("the DUT did not return every input credit");
   end

endmodule

`default_nettype wire
